/* Makefile */
TOP := conv_3x3_engine_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f sources.f -o sim_$(TOP)

# The simulator exits non-zero on a failure, the log decides
run: compile
	-./obj_dir/sim_$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TESTS PASSED" sim.log; then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* common/conv_pkg.sv */
`default_nettype none

`include "conv_settings.svh"

package conv_pkg;

	////////////////////////////////////////
	// Scalar data types
	////////////////////////////////////////

	// One signed pixel sample
	typedef logic signed [`CONV_DATA_WIDTH-1:0] pixel_t;

	// One signed kernel weight
	typedef logic signed [`CONV_DATA_WIDTH-1:0] weight_t;

	// Convolution result at full precision
	typedef logic signed [`CONV_ACC_WIDTH-1:0] acc_t;

	////////////////////////////////////////
	// Grouped types
	////////////////////////////////////////

	// Whole 3x3 kernel, index 0 is the top-left tap
	// and also the first weight sent
	typedef weight_t [`CONV_KERNEL_SIZE-1:0] kernel_t;

	// 3x3 pixel neighbourhood in the same raster order
	// as the kernel taps
	typedef pixel_t [`CONV_KERNEL_SIZE-1:0] window_t;

endpackage

`default_nettype wire

/* common/conv_settings.svh */
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

////////////////////////////////////////
// Data path widths
////////////////////////////////////////

// Pixels and weights share one word size
`define CONV_DATA_WIDTH 16
// Nine 32-bit products need four guard bits
`define CONV_ACC_WIDTH 36

////////////////////////////////////////
// Kernel storage and frame geometry
////////////////////////////////////////

`define CONV_KERNEL_SIZE 9
`define CONV_KERNEL_DEPTH 4
`define CONV_IMG_WIDTH 8
`define CONV_IMG_HEIGHT 6

`endif

/* rtl/cnn_fifo_delay.sv */
`timescale 1ns/100ps
`default_nettype none

module cnn_fifo_delay #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 4
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     write,
	input  logic     read,
	input  payload_t data_in,
	output payload_t data_out,
	output logic     full,
	output logic     empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_write;
	logic             do_read;

	// Circular pointer step, wraps at the last slot
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign full  = (count == CNT_W'(DEPTH));

	// A full FIFO still takes a write when a read frees a slot
	assign do_read  = read && !empty;
	assign do_write = write && (!full || do_read);

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_read)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_write, do_read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage and registered read port
	always_ff @(posedge clk) begin
		if (do_write)
			mem[wr_ptr] <= data_in;
		if (do_read)
			data_out <= mem[rd_ptr];
	end

endmodule

`default_nettype wire

/* rtl/conv_3x3_engine.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_3x3_engine (
	input  logic              clk,
	input  logic              reset,
	input  logic              weight_valid,
	input  logic              load_weights,
	input  logic              pixel_valid,
	input  conv_pkg::weight_t weight_in,
	input  conv_pkg::pixel_t  pixel_in,
	output logic              weights_ready,
	output logic              conv_valid,
	output conv_pkg::acc_t    conv_out
);

	import conv_pkg::*;

	kernel_t kernel;
	window_t window;
	logic    window_valid;

	////////////////////////////////////////
	// Kernel path
	////////////////////////////////////////

	conv_3x3_buffer_weights u_weight_buffer (
		.clk           (clk),
		.reset         (reset),
		.weight_valid  (weight_valid),
		.load_weights  (load_weights),
		.weight_in     (weight_in),
		.kernel        (kernel),
		.weights_ready (weights_ready)
	);

	////////////////////////////////////////
	// Pixel path
	////////////////////////////////////////

	// Window is ready two cycles after its last pixel
	line_window_3x3 u_line_window (
		.clk          (clk),
		.reset        (reset),
		.pixel_valid  (pixel_valid),
		.pixel_in     (pixel_in),
		.window       (window),
		.window_valid (window_valid)
	);

	// Three more cycles through the multiply and adder tree
	conv_3x3_mac u_mac (
		.clk          (clk),
		.reset        (reset),
		.window_valid (window_valid),
		.window       (window),
		.kernel       (kernel),
		.conv_out     (conv_out),
		.conv_valid   (conv_valid)
	);

endmodule

`default_nettype wire

/* rtl/conv_3x3_mac.sv */
`timescale 1ns/100ps
`default_nettype none

`include "conv_settings.svh"

module conv_3x3_mac (
	input  logic              clk,
	input  logic              reset,
	input  logic              window_valid,
	input  conv_pkg::window_t window,
	input  conv_pkg::kernel_t kernel,
	output conv_pkg::acc_t    conv_out,
	output logic              conv_valid
);

	import conv_pkg::*;

	// Terms summed in the first partial sum
	localparam int LO_TERMS = 5;

	logic signed [2*`CONV_DATA_WIDTH-1:0] product [`CONV_KERNEL_SIZE];
	acc_t                                 next_lo;
	acc_t                                 next_hi;
	acc_t                                 sum_lo;
	acc_t                                 sum_hi;
	logic                                 valid_s1;
	logic                                 valid_s2;

	////////////////////////////////////////
	// Stage one, products
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		for (int i = 0; i < `CONV_KERNEL_SIZE; i++) begin
			product[i] <= $signed(window[i]) * $signed(kernel[i]);
		end
	end

	////////////////////////////////////////
	// Stage two, partial sums
	////////////////////////////////////////

	// Products are sign extended to full width before adding
	always_comb begin
		next_lo = '0;
		next_hi = '0;
		for (int i = 0; i < LO_TERMS; i++) begin
			next_lo = next_lo + acc_t'(product[i]);
		end
		for (int i = LO_TERMS; i < `CONV_KERNEL_SIZE; i++) begin
			next_hi = next_hi + acc_t'(product[i]);
		end
	end

	always_ff @(posedge clk) begin
		sum_lo <= next_lo;
		sum_hi <= next_hi;
	end

	////////////////////////////////////////
	// Stage three, total
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		conv_out <= sum_lo + sum_hi;
	end

	// Valid travels with the data
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_s1   <= 1'b0;
			valid_s2   <= 1'b0;
			conv_valid <= 1'b0;
		end else begin
			valid_s1   <= window_valid;
			valid_s2   <= valid_s1;
			conv_valid <= valid_s2;
		end
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
common/conv_pkg.sv
rtl/cnn_fifo_delay.sv
weight_buffer/kernel_weight_loader.sv
weight_buffer/conv_3x3_buffer_weights.sv
window/line_window_3x3.sv
rtl/conv_3x3_mac.sv
rtl/conv_3x3_engine.sv
test/conv_3x3_engine_assertions.sv
test/conv_3x3_engine_tb.sv

/* test/conv_3x3_engine_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_3x3_engine_assertions (
	input logic           clk,
	input logic           reset,
	input logic           weights_ready,
	input logic           conv_valid,
	input conv_pkg::acc_t conv_out,
	input logic           kernel_write,
	input logic           kernel_full
);

	////////////////////////////////////////
	// Output qualification
	////////////////////////////////////////

	// Results only flow once a kernel is active
	property valid_needs_kernel;
		@(posedge clk) disable iff (reset)
			$rose(conv_valid) |-> weights_ready;
	endproperty

	property result_known;
		@(posedge clk) disable iff (reset)
			conv_valid |-> !$isunknown(conv_out);
	endproperty

	// Kernel FIFO overflow
	property no_write_when_full;
		@(posedge clk) disable iff (reset)
			kernel_write |-> !kernel_full;
	endproperty

	a_valid_needs_kernel: assert property (valid_needs_kernel)
		else $error("conv_valid rose with no kernel loaded");

	a_result_known: assert property (result_known)
		else $error("conv_out unknown while conv_valid is high");

	a_no_write_when_full: assert property (no_write_when_full)
		else $error("kernel FIFO written while full");

endmodule

bind conv_3x3_engine conv_3x3_engine_assertions u_assertions (
	.clk           (clk),
	.reset         (reset),
	.weights_ready (weights_ready),
	.conv_valid    (conv_valid),
	.conv_out      (conv_out),
	.kernel_write  (u_weight_buffer.kernel_write),
	.kernel_full   (u_weight_buffer.u_kernel_fifo.full)
);

`default_nettype wire

/* test/conv_3x3_engine_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "conv_settings.svh"

module conv_3x3_engine_tb;

	import conv_pkg::*;

	localparam int CLK_PERIOD      = 100;
	localparam int FRAME_PIXELS    = `CONV_IMG_WIDTH * `CONV_IMG_HEIGHT;
	localparam int NUM_KERNELS     = 4;
	localparam int NUM_FRAMES      = 5;
	localparam int VALID_PER_FRAME = (`CONV_IMG_WIDTH - 2) * (`CONV_IMG_HEIGHT - 2);
	localparam int FIRST_LATENCY   = 5;
	localparam int TIMEOUT_CYCLES  = NUM_KERNELS * FRAME_PIXELS * 3 + 200;

	localparam logic signed [`CONV_DATA_WIDTH-1:0] WORD_MIN = {1'b1, {(`CONV_DATA_WIDTH-1){1'b0}}};
	localparam logic signed [`CONV_DATA_WIDTH-1:0] WORD_MAX = {1'b0, {(`CONV_DATA_WIDTH-1){1'b1}}};

	logic    clk;
	logic    reset;
	logic    weight_valid;
	logic    load_weights;
	logic    pixel_valid;
	weight_t weight_in;
	pixel_t  pixel_in;
	logic    weights_ready;
	logic    conv_valid;
	acc_t    conv_out;

	integer  seed;
	int      cycle_cnt;
	int      strobe_cycle;
	int      first_cycle;
	int      result_total;
	int      frame_base;
	string   test_name;
	weight_t kernels [NUM_KERNELS][`CONV_KERNEL_SIZE];
	pixel_t  frames [NUM_FRAMES][FRAME_PIXELS];
	acc_t    expected_q [$];

	conv_3x3_engine DUT (
		.clk           (clk),
		.reset         (reset),
		.weight_valid  (weight_valid),
		.load_weights  (load_weights),
		.pixel_valid   (pixel_valid),
		.weight_in     (weight_in),
		.pixel_in      (pixel_in),
		.weights_ready (weights_ready),
		.conv_valid    (conv_valid),
		.conv_out      (conv_out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		if (reset)
			cycle_cnt <= 0;
		else
			cycle_cnt <= cycle_cnt + 1;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic report_failure(input string line);
		$display("%s", line);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	function automatic logic signed [`CONV_DATA_WIDTH-1:0] rand_word();
		return `CONV_DATA_WIDTH'($random(seed));
	endfunction

	// Sum over the window whose bottom-right pixel sits at (row, col)
	function automatic acc_t ref_conv(input int f, input int k, input int row, input int col);
		longint sum;
		int     pos;
		sum = 0;
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				pos = (row - 2 + r) * `CONV_IMG_WIDTH + (col - 2 + c);
				sum += longint'(frames[f][pos]) * longint'(kernels[k][3*r + c]);
			end
		end
		return acc_t'(sum);
	endfunction

	// Inputs change just after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_idle();
		assert (!weights_ready && !conv_valid)
			else report_failure($sformatf("%s: outputs active before the first kernel load",
				test_name));
	endtask

	task automatic send_kernel(input int k, input bit expect_idle);
		for (int i = 0; i < `CONV_KERNEL_SIZE; i++) begin
			next_cycle();
			weight_valid = 1'b1;
			weight_in    = kernels[k][i];
			if (expect_idle)
				check_idle();
		end
		next_cycle();
		weight_valid = 1'b0;
	endtask

	task automatic load_kernel();
		logic was_ready;
		was_ready = weights_ready;
		next_cycle();
		load_weights = 1'b1;
		next_cycle();
		load_weights = 1'b0;
		assert (weights_ready == was_ready)
			else report_failure($sformatf("%s: weights_ready changed one cycle after load_weights",
				test_name));
		next_cycle();
		assert (weights_ready)
			else report_failure($sformatf("%s: weights_ready low two cycles after load_weights",
				test_name));
	endtask

	// Expected results go in first, then the pixels with up to max_gap idle cycles
	task automatic run_frame(input int f, input int k, input int max_gap);
		int gap;
		frame_base = result_total;
		for (int row = 2; row < `CONV_IMG_HEIGHT; row++) begin
			for (int col = 2; col < `CONV_IMG_WIDTH; col++) begin
				expected_q.push_back(ref_conv(f, k, row, col));
			end
		end
		for (int p = 0; p < FRAME_PIXELS; p++) begin
			next_cycle();
			pixel_valid = 1'b1;
			pixel_in    = frames[f][p];
			if (p == 2 * `CONV_IMG_WIDTH + 2)
				strobe_cycle = cycle_cnt;
			gap = (max_gap > 0) ? int'($unsigned($random(seed)) % (max_gap + 1)) : 0;
			repeat (gap) begin
				next_cycle();
				pixel_valid = 1'b0;
			end
		end
		next_cycle();
		pixel_valid = 1'b0;
		// Last result lands five cycles after the last strobe
		// and the extra cycles catch a stray one
		repeat (FIRST_LATENCY + 3) next_cycle();
		assert (result_total - frame_base == VALID_PER_FRAME)
			else report_failure($sformatf("error %s: expected %0d results, actual %0d",
				test_name, VALID_PER_FRAME, result_total - frame_base));
	endtask

	////////////////////////////////////////
	// Result checking
	////////////////////////////////////////

	always @(negedge clk) begin : compare_results
		acc_t expected;
		if (!reset && conv_valid) begin
			assert (expected_q.size() != 0)
				else report_failure($sformatf("%s: result arrived with no window expected",
					test_name));
			expected = expected_q.pop_front();
			if (result_total == frame_base)
				first_cycle = cycle_cnt;
			result_total = result_total + 1;
			assert (conv_out === expected)
				else report_failure($sformatf("error %s: expected %0d, actual %0d",
					test_name, expected, conv_out));
		end
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		report_failure("Watchdog expired, results stopped arriving");
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial begin
		seed         = 32'h3a4b37de;
		reset        = 1'b1;
		weight_valid = 1'b0;
		load_weights = 1'b0;
		pixel_valid  = 1'b0;
		weight_in    = '0;
		pixel_in     = '0;
		result_total = 0;
		frame_base   = 0;
		test_name    = "reset state";

		for (int k = 0; k < NUM_KERNELS - 1; k++) begin
			for (int i = 0; i < `CONV_KERNEL_SIZE; i++)
				kernels[k][i] = rand_word();
		end
		for (int f = 0; f < NUM_FRAMES - 1; f++) begin
			for (int p = 0; p < FRAME_PIXELS; p++)
				frames[f][p] = rand_word();
		end
		// Extreme kernel and frame built from the two end values
		for (int i = 0; i < `CONV_KERNEL_SIZE; i++)
			kernels[NUM_KERNELS-1][i] = (i == 4) ? WORD_MAX : WORD_MIN;
		for (int p = 0; p < FRAME_PIXELS; p++)
			frames[NUM_FRAMES-1][p] = (rand_word() < 0) ? WORD_MIN : WORD_MAX;

		repeat (4) begin
			next_cycle();
			check_idle();
		end
		reset = 1'b0;

		test_name = "kernel load";
		for (int k = 0; k < 3; k++)
			send_kernel(k, 1'b1);
		check_idle();
		load_kernel();

		test_name = "first kernel frame";
		run_frame(0, 0, 0);
		assert (first_cycle - strobe_cycle == FIRST_LATENCY)
			else report_failure($sformatf("error %s: expected latency %0d, actual %0d",
				test_name, FIRST_LATENCY, first_cycle - strobe_cycle));

		test_name = "gapped frame";
		run_frame(1, 0, 2);

		test_name = "kernel fifo order";
		load_kernel();
		run_frame(2, 1, 0);
		load_kernel();
		run_frame(3, 2, 0);

		test_name = "signed extremes";
		send_kernel(NUM_KERNELS - 1, 1'b0);
		load_kernel();
		run_frame(NUM_FRAMES - 1, NUM_KERNELS - 1, 0);

		if (expected_q.size() == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("Results still pending at the end of the run");
			$display("TESTS FAILED");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

/* weight_buffer/conv_3x3_buffer_weights.sv */
`timescale 1ns/100ps
`default_nettype none

`include "conv_settings.svh"

module conv_3x3_buffer_weights (
	input  logic              clk,
	input  logic              reset,
	input  logic              weight_valid,
	input  logic              load_weights,
	input  conv_pkg::weight_t weight_in,
	output conv_pkg::kernel_t kernel,
	output logic              weights_ready
);

	import conv_pkg::*;

	logic    kernel_write;
	kernel_t kernel_data;
	kernel_t fifo_kernel;
	logic    kernel_empty;
	logic    load_hit;

	kernel_weight_loader u_loader (
		.clk          (clk),
		.reset        (reset),
		.weight_valid (weight_valid),
		.weight_in    (weight_in),
		.kernel_write (kernel_write),
		.kernel_data  (kernel_data)
	);

	// Queue of complete kernels waiting to become active
	cnn_fifo_delay #(
		.payload_t (kernel_t),
		.DEPTH     (`CONV_KERNEL_DEPTH)
	) u_kernel_fifo (
		.clk      (clk),
		.reset    (reset),
		.write    (kernel_write),
		.read     (load_weights),
		.data_in  (kernel_data),
		.data_out (fifo_kernel),
		.full     (),
		.empty    (kernel_empty)
	);

	////////////////////////////////////////
	// Active kernel register
	////////////////////////////////////////

	// FIFO data shows up one cycle after the read
	always_ff @(posedge clk) begin
		if (reset) begin
			load_hit      <= 1'b0;
			weights_ready <= 1'b0;
		end else begin
			load_hit <= load_weights && !kernel_empty;
			if (load_hit)
				weights_ready <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (load_hit)
			kernel <= fifo_kernel;
	end

endmodule

`default_nettype wire

/* weight_buffer/kernel_weight_loader.sv */
`timescale 1ns/100ps
`default_nettype none

`include "conv_settings.svh"

module kernel_weight_loader (
	input  logic              clk,
	input  logic              reset,
	input  logic              weight_valid,
	input  conv_pkg::weight_t weight_in,
	output logic              kernel_write,
	output conv_pkg::kernel_t kernel_data
);

	localparam int CNT_W = $clog2(`CONV_KERNEL_SIZE);

	logic [CNT_W-1:0] weight_cnt;
	logic             group_done;

	// Ninth weight of the current group is being accepted
	assign group_done = weight_valid && (weight_cnt == CNT_W'(`CONV_KERNEL_SIZE - 1));

	////////////////////////////////////////
	// Shift chain
	////////////////////////////////////////

	// New weights enter at the top index and walk down,
	// so the first weight of a group settles at index 0
	always_ff @(posedge clk) begin
		if (weight_valid) begin
			for (int i = 0; i < `CONV_KERNEL_SIZE - 1; i++) begin
				kernel_data[i] <= kernel_data[i+1];
			end
			kernel_data[`CONV_KERNEL_SIZE-1] <= weight_in;
		end
	end

	////////////////////////////////////////
	// Group counter and write strobe
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			weight_cnt   <= '0;
			kernel_write <= 1'b0;
		end else begin
			kernel_write <= group_done;
			if (group_done)
				weight_cnt <= '0;
			else if (weight_valid)
				weight_cnt <= weight_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* window/line_window_3x3.sv */
`timescale 1ns/100ps
`default_nettype none

`include "conv_settings.svh"

module line_window_3x3 (
	input  logic              clk,
	input  logic              reset,
	input  logic              pixel_valid,
	input  conv_pkg::pixel_t  pixel_in,
	output conv_pkg::window_t window,
	output logic              window_valid
);

	import conv_pkg::*;

	localparam int COL_W = $clog2(`CONV_IMG_WIDTH);
	localparam int ROW_W = $clog2(`CONV_IMG_HEIGHT);

	logic [COL_W-1:0] col_cnt;
	logic [ROW_W-1:0] row_cnt;
	logic             valid_d1;
	logic             valid_d2;
	logic             complete_d1;
	logic             row1_full;
	logic             row2_full;
	pixel_t           row1_out;
	pixel_t           row2_out;
	pixel_t           pix_d1;
	pixel_t           pix_d2;
	pixel_t           mid_d2;
	pixel_t           live [3];
	pixel_t           taps [3][2];

	////////////////////////////////////////
	// Row delay lines
	////////////////////////////////////////

	// Row above, one cycle after the strobe
	cnn_fifo_delay #(
		.payload_t (pixel_t),
		.DEPTH     (`CONV_IMG_WIDTH)
	) u_row1 (
		.clk      (clk),
		.reset    (reset),
		.write    (pixel_valid),
		.read     (pixel_valid && row1_full),
		.data_in  (pixel_in),
		.data_out (row1_out),
		.full     (row1_full),
		.empty    ()
	);

	// Two rows above, fed from the first line on the delayed strobe
	cnn_fifo_delay #(
		.payload_t (pixel_t),
		.DEPTH     (`CONV_IMG_WIDTH)
	) u_row2 (
		.clk      (clk),
		.reset    (reset),
		.write    (valid_d1),
		.read     (valid_d1 && row2_full),
		.data_in  (row1_out),
		.data_out (row2_out),
		.full     (row2_full),
		.empty    ()
	);

	////////////////////////////////////////
	// Position tracking
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			col_cnt      <= '0;
			row_cnt      <= '0;
			valid_d1     <= 1'b0;
			valid_d2     <= 1'b0;
			complete_d1  <= 1'b0;
			window_valid <= 1'b0;
		end else begin
			valid_d1     <= pixel_valid;
			valid_d2     <= valid_d1;
			complete_d1  <= pixel_valid && (col_cnt >= COL_W'(2)) && (row_cnt >= ROW_W'(2));
			window_valid <= complete_d1;
			if (pixel_valid) begin
				if (col_cnt == COL_W'(`CONV_IMG_WIDTH - 1)) begin
					col_cnt <= '0;
					row_cnt <= (row_cnt == ROW_W'(`CONV_IMG_HEIGHT - 1)) ? '0 : row_cnt + 1'b1;
				end else begin
					col_cnt <= col_cnt + 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////
	// Window columns
	////////////////////////////////////////

	// Align current and middle rows with the second delay line
	always_ff @(posedge clk) begin
		if (pixel_valid)
			pix_d1 <= pixel_in;
		if (valid_d1) begin
			pix_d2 <= pix_d1;
			mid_d2 <= row1_out;
		end
	end

	// Newest column, top to bottom
	assign live[0] = row2_out;
	assign live[1] = mid_d2;
	assign live[2] = pix_d2;

	// Older columns move left once the newest one has been used
	always_ff @(posedge clk) begin
		if (valid_d2) begin
			for (int r = 0; r < 3; r++) begin
				taps[r][0] <= taps[r][1];
				taps[r][1] <= live[r];
			end
		end
	end

	always_comb begin
		for (int r = 0; r < 3; r++) begin
			window[3*r]     = taps[r][0];
			window[3*r + 1] = taps[r][1];
			window[3*r + 2] = live[r];
		end
	end

endmodule

`default_nettype wire
